// ==== Makefile ====
# Verilator build and run for the AXI4 TMR voter testbench

VERILATOR ?= verilator
TOP       ?= tb_tmr_axi_voter
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FLIST)

# Result is decided by the pass line in the log
run: $(BIN)
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/tmr_axi_voter.sv ====
// AXI4 TMR voter top level with request fan-out, response voting and fault record
`default_nettype none

module tmr_axi_voter (
    input  logic                                                   clk,
    input  logic                                                   rst,

    // Manager side requests
    input  tmr_pkg::axi_aw_t                                       s_aw,
    input  logic                                                   s_awvalid,
    output logic                                                   s_awready,
    input  tmr_pkg::axi_w_t                                        s_w,
    input  logic                                                   s_wvalid,
    output logic                                                   s_wready,
    input  tmr_pkg::axi_ar_t                                       s_ar,
    input  logic                                                   s_arvalid,
    output logic                                                   s_arready,

    // Manager side responses
    output tmr_pkg::axi_b_t                                        s_b,
    output logic                                                   s_bvalid,
    input  logic                                                   s_bready,
    output tmr_pkg::axi_r_t                                        s_r,
    output logic                                                   s_rvalid,
    input  logic                                                   s_rready,

    // Shared outputs to all three copies
    output tmr_pkg::axi_aw_t                                       m_aw,
    output logic                                                   m_awvalid,
    output tmr_pkg::axi_w_t                                        m_w,
    output logic                                                   m_wvalid,
    output tmr_pkg::axi_ar_t                                       m_ar,
    output logic                                                   m_arvalid,
    output logic                                                   m_bready,
    output logic                                                   m_rready,

    // Per-copy responses
    input  tmr_pkg::tmr_ready_vote_t [tmr_pkg::tmr_copies-1:0]     m_ready,
    input  tmr_pkg::tmr_b_vote_t     [tmr_pkg::tmr_copies-1:0]     m_b,
    input  tmr_pkg::tmr_r_vote_t     [tmr_pkg::tmr_copies-1:0]     m_r,

    output tmr_pkg::tmr_fault_t                                    fault
);

    import tmr_pkg::*;

    tmr_ready_vote_t            ready_voted;
    tmr_b_vote_t                b_voted;
    tmr_r_vote_t                r_voted;

    logic                       ready_fault;
    logic                       b_fault;
    logic                       r_fault;
    logic [fault_index_w-1:0]   ready_index;
    logic [fault_index_w-1:0]   b_index;
    logic [fault_index_w-1:0]   r_index;
    logic [tmr_copies-1:0]      ready_dissent;
    logic [tmr_copies-1:0]      b_dissent;
    logic [tmr_copies-1:0]      r_dissent;

    // Requests reach every copy unchanged
    assign m_aw      = s_aw;
    assign m_awvalid = s_awvalid;
    assign m_w       = s_w;
    assign m_wvalid  = s_wvalid;
    assign m_ar      = s_ar;
    assign m_arvalid = s_arvalid;
    assign m_bready  = s_bready;
    assign m_rready  = s_rready;

    tmr_channel_voter #(
        .payload_t (tmr_ready_vote_t)
    ) ready_voter_i (
        .copies    (m_ready),
        .voted     (ready_voted),
        .fault     (ready_fault),
        .bit_index (ready_index),
        .dissent   (ready_dissent)
    );

    tmr_channel_voter #(
        .payload_t (tmr_b_vote_t)
    ) b_voter_i (
        .copies    (m_b),
        .voted     (b_voted),
        .fault     (b_fault),
        .bit_index (b_index),
        .dissent   (b_dissent)
    );

    tmr_channel_voter #(
        .payload_t (tmr_r_vote_t)
    ) r_voter_i (
        .copies    (m_r),
        .voted     (r_voted),
        .fault     (r_fault),
        .bit_index (r_index),
        .dissent   (r_dissent)
    );

    // Voted groups back onto the manager ports
    assign s_awready = ready_voted.awready;
    assign s_wready  = ready_voted.wready;
    assign s_arready = ready_voted.arready;

    assign s_bvalid = b_voted.bvalid;
    assign s_b      = '{id: b_voted.bid, resp: b_voted.bresp};

    assign s_rvalid = r_voted.rvalid;
    assign s_r      = '{id:   r_voted.rid,
                        data: r_voted.rdata,
                        resp: r_voted.rresp,
                        last: r_voted.rlast};

    tmr_fault_recorder recorder_i (
        .clk           (clk),
        .rst           (rst),
        .ready_fault   (ready_fault),
        .b_fault       (b_fault),
        .r_fault       (r_fault),
        .ready_index   (ready_index),
        .b_index       (b_index),
        .r_index       (r_index),
        .ready_dissent (ready_dissent),
        .b_dissent     (b_dissent),
        .r_dissent     (r_dissent),
        .fault         (fault)
    );

endmodule

`default_nettype wire

// ==== design/tmr_channel_voter.sv ====
// Bitwise majority voter over three copies of one payload type
`default_nettype none

module tmr_channel_voter #(
    parameter type payload_t = logic
) (
    input  payload_t [tmr_pkg::tmr_copies-1:0] copies,
    output payload_t                           voted,
    output logic                               fault,
    output logic [tmr_pkg::fault_index_w-1:0]  bit_index,
    output logic [tmr_pkg::tmr_copies-1:0]     dissent
);

    import tmr_pkg::*;

    // Flat view of the copies so the vote works on plain vectors
    logic [tmr_copies-1:0][$bits(payload_t)-1:0] flat;
    logic [$bits(payload_t)-1:0]                 majority;
    logic [$bits(payload_t)-1:0]                 differ;

    assign flat = copies;

    // Two out of three per bit
    assign majority = (flat[0] & flat[1])
                    | (flat[0] & flat[2])
                    | (flat[1] & flat[2]);

    // A bit disagrees when any copy differs from copy 0
    assign differ = (flat[0] ^ flat[1]) | (flat[0] ^ flat[2]);

    assign voted = payload_t'(majority);
    assign fault = |differ;

    // Lowest disagreeing bit wins, scan from the top so bit 0 lands last
    always_comb begin
        bit_index = '0;
        for (int i = $bits(payload_t) - 1; i >= 0; i--) begin
            if (differ[i]) begin
                bit_index = fault_index_w'(i);
            end
        end
    end

    // A copy is outvoted if it leaves the majority on any bit
    always_comb begin
        dissent = '0;
        for (int n = 0; n < tmr_copies; n++) begin
            dissent[n] = |(flat[n] ^ majority);
        end
    end

endmodule

`default_nettype wire

// ==== design/tmr_fault_recorder.sv ====
// Group fault prioritizer and sticky first-fault record
`default_nettype none

module tmr_fault_recorder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ready_fault,
    input  logic                              b_fault,
    input  logic                              r_fault,
    input  logic [tmr_pkg::fault_index_w-1:0] ready_index,
    input  logic [tmr_pkg::fault_index_w-1:0] b_index,
    input  logic [tmr_pkg::fault_index_w-1:0] r_index,
    input  logic [tmr_pkg::tmr_copies-1:0]    ready_dissent,
    input  logic [tmr_pkg::tmr_copies-1:0]    b_dissent,
    input  logic [tmr_pkg::tmr_copies-1:0]    r_dissent,
    output tmr_pkg::tmr_fault_t               fault
);

    import tmr_pkg::*;

    tmr_fault_t fault_next;
    logic       record_open;

    // Ready group first, then B, then R
    always_comb begin
        fault_next = '0;
        if (ready_fault) begin
            fault_next.group     = group_ready;
            fault_next.bit_index = ready_index;
            fault_next.dissent   = ready_dissent;
        end else if (b_fault) begin
            fault_next.group     = group_b;
            fault_next.bit_index = b_index;
            fault_next.dissent   = b_dissent;
        end else if (r_fault) begin
            fault_next.group     = group_r;
            fault_next.bit_index = r_index;
            fault_next.dissent   = r_dissent;
        end
    end

    // Only an empty record accepts a new fault
    assign record_open = (fault.group == group_none);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fault <= '0;
        end else if (record_open) begin
            // Loads zero again when nothing disagrees
            fault <= fault_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/tmr_pkg.sv ====
// Widths, AXI channel payloads, response vote groups and the fault record
`default_nettype none

package tmr_pkg;

    // Redundancy and bus geometry
    localparam int tmr_copies    = 3;
    localparam int addr_w        = 32;
    localparam int data_w        = 32;
    localparam int id_w          = 4;
    localparam int strb_w        = data_w / 8;
    localparam int fault_index_w = 6;

    // Address channel payload, valid travels separately
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [2:0]        prot;
    } axi_aw_t;

    // Read address uses the same field set as write address
    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    // Manager side response payloads
    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    // Vote groups, one per response path returned by each copy
    typedef struct packed {
        logic awready;
        logic wready;
        logic arready;
    } tmr_ready_vote_t;

    typedef struct packed {
        logic            bvalid;
        logic [id_w-1:0] bid;
        logic [1:0]      bresp;
    } tmr_b_vote_t;

    typedef struct packed {
        logic              rvalid;
        logic [id_w-1:0]   rid;
        logic [data_w-1:0] rdata;
        logic [1:0]        rresp;
        logic              rlast;
    } tmr_r_vote_t;

    typedef enum logic [1:0] {
        group_none  = 2'd0,
        group_ready = 2'd1,
        group_b     = 2'd2,
        group_r     = 2'd3
    } tmr_group_e;

    // Bit n of dissent set means copy n was outvoted
    typedef struct packed {
        tmr_group_e               group;
        logic [fault_index_w-1:0] bit_index;
        logic [tmr_copies-1:0]    dissent;
    } tmr_fault_t;

endpackage

`default_nettype wire

// ==== flist.f ====
design/tmr_pkg.sv
design/tmr_channel_voter.sv
design/tmr_fault_recorder.sv
design/tmr_axi_voter.sv
verif/tmr_voter_properties.sv
verif/tb_tmr_axi_voter.sv

// ==== verif/tb_tmr_axi_voter.sv ====
// Testbench for the AXI4 TMR voter with clock, reset, LFSR stimulus, checks and directed tests
`default_nettype none

module tb_tmr_axi_voter;

    timeunit 1ns;
    timeprecision 100ps;

    import tmr_pkg::*;

    localparam int fault_timeout = 10;
    localparam int sweep_cycles  = 24;

    logic            clk;
    logic            rst;
    axi_aw_t         s_aw;
    logic            s_awvalid;
    logic            s_awready;
    axi_w_t          s_w;
    logic            s_wvalid;
    logic            s_wready;
    axi_ar_t         s_ar;
    logic            s_arvalid;
    logic            s_arready;
    axi_b_t          s_b;
    logic            s_bvalid;
    logic            s_bready;
    axi_r_t          s_r;
    logic            s_rvalid;
    logic            s_rready;
    axi_aw_t         m_aw;
    logic            m_awvalid;
    axi_w_t          m_w;
    logic            m_wvalid;
    axi_ar_t         m_ar;
    logic            m_arvalid;
    logic            m_bready;
    logic            m_rready;
    tmr_ready_vote_t [tmr_copies-1:0] m_ready;
    tmr_b_vote_t     [tmr_copies-1:0] m_b;
    tmr_r_vote_t     [tmr_copies-1:0] m_r;
    tmr_fault_t      fault;

    // Value the healthy copies return
    tmr_ready_vote_t ready_good;
    tmr_b_vote_t     b_good;
    tmr_r_vote_t     r_good;

    logic [31:0]     lfsr_state = 32'h2752;

    tmr_axi_voter dut_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_r       (s_r),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_bready  (m_bready),
        .m_rready  (m_rready),
        .m_ready   (m_ready),
        .m_b       (m_b),
        .m_r       (m_r),
        .fault     (fault)
    );

    bind tmr_axi_voter tmr_voter_properties props_i (
        .clk      (clk),
        .rst      (rst),
        .m_b      (m_b),
        .s_bvalid (s_bvalid),
        .fault    (fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int rand_below(input int limit);
        return int'(rand_bits(8)) % limit;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic pick_goods();
        logic [63:0] raw;
        raw = rand_bits($bits(tmr_ready_vote_t));
        ready_good = raw[$bits(tmr_ready_vote_t)-1:0];
        raw = rand_bits($bits(tmr_b_vote_t));
        b_good = raw[$bits(tmr_b_vote_t)-1:0];
        raw = rand_bits($bits(tmr_r_vote_t));
        r_good = raw[$bits(tmr_r_vote_t)-1:0];
    endtask

    // Called right after a rising edge
    task automatic drive_agreement();
        m_ready <= {tmr_copies{ready_good}};
        m_b     <= {tmr_copies{b_good}};
        m_r     <= {tmr_copies{r_good}};
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b0;
        drive_agreement();
        @(negedge clk);
        check(64'(fault), 64'd0, "fault during reset");
        @(posedge clk);
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check(64'(fault), 64'd0, "fault after reset release");
    endtask

    // Manager ports must match the healthy copy value
    task automatic check_voted();
        check(64'({s_awready, s_wready, s_arready}), 64'(ready_good), "voted ready group");
        check(64'({s_bvalid, s_b}), 64'(b_good), "voted B group");
        check(64'({s_rvalid, s_r}), 64'(r_good), "voted R group");
    endtask

    task automatic wait_for_fault(output int cycles);
        cycles = 0;
        while (fault.group == group_none) begin
            if (cycles == fault_timeout) begin
                abort_run("Timeout: no fault was recorded within the cycle limit");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_fault(input tmr_group_e grp, input int index, input int copy);
        check(64'(fault.group), 64'(grp), "fault group");
        check(64'(fault.bit_index), 64'(index), "fault bit index");
        check(64'(fault.dissent), 64'd1 << copy, "fault dissent");
    endtask

    task automatic test_fanout();
        logic [63:0] raw;
        axi_aw_t     aw_v;
        axi_w_t      w_v;
        axi_ar_t     ar_v;
        logic [4:0]  flags;
        for (int i = 0; i < sweep_cycles; i++) begin
            raw = rand_bits($bits(axi_aw_t));
            aw_v = raw[$bits(axi_aw_t)-1:0];
            raw = rand_bits($bits(axi_w_t));
            w_v = raw[$bits(axi_w_t)-1:0];
            raw = rand_bits($bits(axi_ar_t));
            ar_v = raw[$bits(axi_ar_t)-1:0];
            raw = rand_bits(5);
            flags = raw[4:0];
            @(posedge clk);
            s_aw      <= aw_v;
            s_w       <= w_v;
            s_ar      <= ar_v;
            s_awvalid <= flags[4];
            s_wvalid  <= flags[3];
            s_arvalid <= flags[2];
            s_bready  <= flags[1];
            s_rready  <= flags[0];
            @(negedge clk);
            check(64'(m_aw), 64'(aw_v), "m_aw fan-out");
            check(64'(m_w), 64'(w_v), "m_w fan-out");
            check(64'(m_ar), 64'(ar_v), "m_ar fan-out");
            check(64'({m_awvalid, m_wvalid, m_arvalid, m_bready, m_rready}), 64'(flags),
                  "valid and ready fan-out");
        end
    endtask

    task automatic test_agreement();
        for (int i = 0; i < sweep_cycles; i++) begin
            pick_goods();
            @(posedge clk);
            drive_agreement();
            @(negedge clk);
            check_voted();
            check(64'(fault), 64'd0, "fault while all copies agree");
        end
    endtask

    task automatic test_r_corruption(output int copy);
        logic [$bits(tmr_r_vote_t)-1:0] mask;
        int bit_k;
        int cycles;
        bit_k = rand_below($bits(tmr_r_vote_t));
        copy = rand_below(tmr_copies);
        mask = '0;
        mask[bit_k] = 1'b1;
        @(posedge clk);
        for (int n = 0; n < tmr_copies; n++) begin
            m_r[n] <= (n == copy) ? tmr_r_vote_t'(r_good ^ mask) : r_good;
        end
        @(negedge clk);
        check_voted();
        check(64'(fault.group), 64'(group_none), "fault before the recording edge");
        wait_for_fault(cycles);
        check(64'(cycles), 64'd1, "cycles from R disagreement to record");
        check_fault(group_r, bit_k, copy);
    endtask

    // A later B disagreement in another copy must leave the record alone
    task automatic test_sticky(input int r_copy);
        logic [$bits(tmr_b_vote_t)-1:0] mask;
        tmr_fault_t held;
        int copy;
        int bit_i;
        held = fault;
        copy = (r_copy + 1) % tmr_copies;
        bit_i = rand_below($bits(tmr_b_vote_t));
        mask = '0;
        mask[bit_i] = 1'b1;
        @(posedge clk);
        m_r <= {tmr_copies{r_good}};
        for (int n = 0; n < tmr_copies; n++) begin
            m_b[n] <= (n == copy) ? tmr_b_vote_t'(b_good ^ mask) : b_good;
        end
        repeat (4) begin
            @(negedge clk);
            check_voted();
            check(64'(fault), 64'(held), "held fault after a later B disagreement");
        end
    endtask

    task automatic test_priority();
        logic [$bits(tmr_ready_vote_t)-1:0] ready_mask;
        logic [$bits(tmr_b_vote_t)-1:0]     b_mask;
        int bit_j;
        int bit_i;
        int cycles;
        apply_reset();
        bit_j = rand_below($bits(tmr_ready_vote_t));
        bit_i = rand_below($bits(tmr_b_vote_t));
        ready_mask = '0;
        ready_mask[bit_j] = 1'b1;
        b_mask = '0;
        b_mask[bit_i] = 1'b1;
        @(posedge clk);
        m_ready[0] <= tmr_ready_vote_t'(ready_good ^ ready_mask);
        m_ready[1] <= ready_good;
        m_ready[2] <= ready_good;
        m_b[0] <= b_good;
        m_b[1] <= tmr_b_vote_t'(b_good ^ b_mask);
        m_b[2] <= b_good;
        @(negedge clk);
        check_voted();
        wait_for_fault(cycles);
        check(64'(cycles), 64'd1, "cycles from ready disagreement to record");
        check_fault(group_ready, bit_j, 0);
    endtask

    task automatic test_reset_clear();
        logic [$bits(tmr_b_vote_t)-1:0] mask;
        int copy;
        int bit_i;
        int cycles;
        apply_reset();
        pick_goods();
        @(posedge clk);
        drive_agreement();
        @(negedge clk);
        check_voted();
        check(64'(fault), 64'd0, "fault after reset with agreeing copies");
        copy = rand_below(tmr_copies);
        bit_i = rand_below($bits(tmr_b_vote_t));
        mask = '0;
        mask[bit_i] = 1'b1;
        @(posedge clk);
        for (int n = 0; n < tmr_copies; n++) begin
            m_b[n] <= (n == copy) ? tmr_b_vote_t'(b_good ^ mask) : b_good;
        end
        @(negedge clk);
        check_voted();
        wait_for_fault(cycles);
        check(64'(cycles), 64'd1, "cycles from B disagreement to record");
        check_fault(group_b, bit_i, copy);
    endtask

    initial begin
        int r_copy;
        rst        = 1'b0;
        s_aw       = '0;
        s_awvalid  = 1'b0;
        s_w        = '0;
        s_wvalid   = 1'b0;
        s_ar       = '0;
        s_arvalid  = 1'b0;
        s_bready   = 1'b0;
        s_rready   = 1'b0;
        m_ready    = '0;
        m_b        = '0;
        m_r        = '0;
        ready_good = '0;
        b_good     = '0;
        r_good     = '0;
        apply_reset();
        test_fanout();
        test_agreement();
        test_r_corruption(r_copy);
        test_sticky(r_copy);
        test_priority();
        test_reset_clear();
        @(negedge clk);
        if (dut_i.props_i.failures != 0) begin
            $display("Assertion failures: %0d", dut_i.props_i.failures);
            $display("FAIL: see errors above");
            $fatal(1, "assertions failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tmr_voter_properties.sv ====
// Concurrent assertions bound to the AXI4 TMR voter top level
`default_nettype none

module tmr_voter_properties (
    input  logic                                               clk,
    input  logic                                               rst,
    input  tmr_pkg::tmr_b_vote_t [tmr_pkg::tmr_copies-1:0]     m_b,
    input  logic                                               s_bvalid,
    input  tmr_pkg::tmr_fault_t                                fault
);

    timeunit 1ns;
    timeprecision 100ps;

    import tmr_pkg::*;

    // Failed assertion count read by the testbench at the end
    int unsigned failures = 0;

    logic bvalid_majority;

    // At least two of the three copies raise bvalid
    assign bvalid_majority = (2'(m_b[0].bvalid) + 2'(m_b[1].bvalid) + 2'(m_b[2].bvalid))
                           >= 2'd2;

    // A held fault record stays frozen until reset
    fault_sticky_a: assert property (@(posedge clk) disable iff (!rst)
        (fault.group != group_none) |=> $stable(fault))
    else begin
        failures++;
        $error("fault record changed while a fault was held");
    end

    // Voted bvalid follows two out of three
    bvalid_vote_a: assert property (@(posedge clk) s_bvalid == bvalid_majority)
    else begin
        failures++;
        $error("s_bvalid differs from the bvalid majority");
    end

    // Record starts out empty right after reset release
    fault_clear_a: assert property (@(posedge clk) $rose(rst) |-> (fault == '0))
    else begin
        failures++;
        $error("fault record not empty after reset release");
    end

endmodule

`default_nettype wire
